// File: verif/spim_golden.txt
// Word 0 is the transfer count, then one transfer per line
// div mode dir len txdata slave_pattern expected_rx (hex; mode 0/1/2 = single/dual/quad; dir 1 = read)
0a
03 0 0 08 c3a50f96 5a000000 0000005a
03 0 0 00 12345678 deadbeef deadbeef
04 1 1 10 ffffffff beef1234 0000beef
03 2 1 20 00000000 0123abcd 0123abcd
05 2 1 0e 00000000 9876ffff 00001876
03 1 0 07 b4000000 e7000000 00000067
03 2 0 0c a5c33333 3c9fffff 000003c9
06 0 1 05 00000000 a8000000 00000015
03 1 1 05 ffffffff d4000000 00000015
0a 2 0 20 fedcba98 13579bdf 13579bdf

// File: src.f
logic/spim_pkg.sv
logic/spim_regs.sv
logic/spim_clkgen.sv
logic/spim_tx.sv
logic/spim_rx.sv
logic/spim_top.sv
verif/spim_assertions.sv
verif/spim_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module spim_tb -o spim_sim
out=$(./obj_dir/spim_sim +verilator+error+limit+100 2>&1) || true
echo "$out"
if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1

// File: verif/spim_tb.sv
`timescale 1ns/1ps

module spim_tb;
  import spim_pkg::*;

  localparam int FIELDS    = 7;   // div mode dir len txdata pattern rx
  localparam int MAX_TESTS = 32;
  localparam spim_status_t ST_RUNNING = '{busy: 1'b1, done: 1'b0};
  localparam spim_status_t ST_DONE    = '{busy: 1'b0, done: 1'b1};

  logic        clk;
  logic        rstn;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        sclk;
  logic        csn;
  logic [3:0]  sdo;
  logic [3:0]  sdo_oe;
  logic [3:0]  sdi = 4'h0;

  logic [31:0] golden [0:FIELDS*MAX_TESTS];  // Word 0 is the test count
  logic [15:0] lfsr;
  int          n_tests;
  int          max_div;
  int          n_checks;
  int          n_errors;
  int          n_writes;
  int          n_reads;
  int          b_seen;
  int          r_seen;
  bit          loaded;

  // ------------------------------
  // SPI slave model state
  // ------------------------------
  spim_mode_e  cur_mode = MODE_SINGLE;
  spim_dir_e   cur_dir = DIR_WRITE;
  int          cur_lines = 1;
  logic [31:0] cur_pattern = '0;
  int          chunk_idx = 0;   // Pattern chunk on sdi now
  int          rises = 0;       // Rising sclk edges this transfer
  logic [31:0] sdo_bits = '0;   // Bits sampled from sdo, right-aligned
  logic        sclk_q = 1'b0;
  logic        csn_q = 1'b1;

  spim_top u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready),
    .sclk_o      (sclk),
    .csn_o       (csn),
    .sdo_o       (sdo),
    .sdo_oe_o    (sdo_oe),
    .sdi_i       (sdi)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // BREADY / RREADY hold-off, 0 to 3 cycles
  task automatic ready_delay(output int d);
    d = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      d = (d << 1) | lfsr[0];
    end
  endtask

  function automatic int lines_for(spim_mode_e mode);
    case (mode)
      MODE_QUAD: return 4;
      MODE_DUAL: return 2;
      default:   return 1;
    endcase
  endfunction

  // Slave output for one chunk, MSB first, MISO on line 1 in single mode
  function automatic logic [3:0] slave_lanes(logic [31:0] pat, int lines, int idx);
    logic [31:0] w;
    w = pat << (lines * idx);
    case (lines)
      4:       return w[31:28];
      2:       return {2'b00, w[31:30]};
      default: return {2'b00, w[31], 1'b0};
    endcase
  endfunction

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(string name, logic [1:0] got, logic [1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_status(string name, spim_status_t got, spim_status_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s got busy/done %b expected %b", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // AXI4-Lite driver
  // ------------------------------
  task automatic axi_write(logic [7:0] addr, logic [31:0] data, output logic [1:0] resp);
    bit aw_hit;
    bit w_hit;
    bit aw_done;
    bit w_done;
    int dly;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      aw_hit = awvalid && awready;  // Handshake on the coming edge
      w_hit  = wvalid && wready;
      @(posedge clk);
      if (aw_hit) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hit) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
    end
    n_writes++;
    ready_delay(dly);
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    repeat (dly) @(negedge clk);
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    if (!bvalid) begin
      n_errors++;
      $display("Write response to %h dropped before BREADY at %0t", addr, $time);
    end
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
    @(negedge clk);
    if (bvalid) begin
      n_errors++;
      $display("Write response to %h repeated after its handshake at %0t", addr, $time);
    end
  endtask

  task automatic axi_read(logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    bit ar_hit;
    int dly;
    ar_hit = 1'b0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    while (!ar_hit) begin
      @(negedge clk);
      ar_hit = arvalid && arready;
      @(posedge clk);
    end
    arvalid <= 1'b0;
    n_reads++;
    ready_delay(dly);
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    repeat (dly) @(negedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    if (!rvalid) begin
      n_errors++;
      $display("Read data from %h dropped before RREADY at %0t", addr, $time);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
    @(negedge clk);
    if (rvalid) begin
      n_errors++;
      $display("Read data from %h repeated after its handshake at %0t", addr, $time);
    end
  endtask

  // ------------------------------
  // SPI slave model
  // ------------------------------
  always @(negedge clk) begin
    if (csn_q && !csn) begin      // New transfer, first chunk
      chunk_idx = 0;
      rises     = 0;
      sdo_bits  = '0;
    end
    if (sclk_q && !sclk && !csn) chunk_idx++;  // Falling edge, next chunk
    if (!sclk_q && sclk) begin
      rises++;
      sdo_bits = (sdo_bits << cur_lines) | (sdo & ((4'd1 << cur_lines) - 4'd1));
      if (cur_mode == MODE_SINGLE) check_word("sdo[3:2]", sdo[3:2], 32'd3);  // WP, HOLD
      if (cur_dir == DIR_READ && cur_mode != MODE_SINGLE) begin
        check_word("sdo_oe[3:1]", sdo_oe[3:1], 32'd0);
      end
    end
    sclk_q = sclk;
    csn_q  = csn;
  end

  always @(posedge clk) sdi <= slave_lanes(cur_pattern, cur_lines, chunk_idx);

  // Handshakes seen on B and R
  always @(negedge clk) begin
    if (bvalid && bready) b_seen++;
    if (rvalid && rready) r_seen++;
  end

  task automatic report_test(string name, int errs_before);
    $display("%s: %s", name, (n_errors == errs_before) ? "ok" : "FAILED");
  endtask

  // One golden line, one transfer
  task automatic run_transfer(int t);
    int           base;
    int           n;
    int           edges;
    int           errs_before;
    logic [7:0]   div;
    logic [5:0]   len;
    logic [31:0]  tx;
    logic [31:0]  exp_rx;
    logic [31:0]  data;
    logic [1:0]   resp;
    spim_status_t st;
    errs_before = n_errors;
    base        = 1 + t * FIELDS;
    div         = golden[base][7:0];
    cur_mode    = spim_mode_e'(golden[base+1][1:0]);
    cur_dir     = spim_dir_e'(golden[base+2][0]);
    len         = golden[base+3][5:0];
    tx          = golden[base+4];
    cur_pattern = golden[base+5];
    exp_rx      = golden[base+6];
    cur_lines   = lines_for(cur_mode);
    n           = (len == 0 || len > 32) ? 32 : int'(len);
    edges       = (n + cur_lines - 1) / cur_lines;  // Rounded up per lane count

    axi_write(REG_CTRL, {24'd0, div}, resp);
    check_resp("bresp CTRL", resp, RESP_OKAY);
    axi_write(REG_TXDATA, tx, resp);
    check_resp("bresp TXDATA", resp, RESP_OKAY);
    axi_write(REG_CMD, {18'd0, len, 3'd0, cur_dir, 2'd0, cur_mode}, resp);
    check_resp("bresp CMD", resp, RESP_OKAY);
    axi_read(REG_STATUS, data, resp);
    check_status("status after CMD", spim_status_t'(data[1:0]), ST_RUNNING);
    // Second command mid-word, must bounce
    axi_write(REG_CMD, 32'h0000_2002, resp);
    check_resp("bresp CMD while busy", resp, RESP_SLVERR);

    do begin
      axi_read(REG_STATUS, data, resp);
      st = spim_status_t'(data[1:0]);
      if (!st.done) check_status("status polled", st, ST_RUNNING);
    end while (!st.done);
    check_status("status at end", st, ST_DONE);
    check_word("csn", csn, 32'd1);  // CS back up with done

    axi_read(REG_RXDATA, data, resp);
    check_resp("rresp RXDATA", resp, RESP_OKAY);
    check_word("rx_word", data, exp_rx);
    check_word("sclk_rises", rises, edges);
    if (cur_dir == DIR_WRITE) begin
      check_word("sdo_bits", sdo_bits, tx >> (32 - cur_lines * edges));
    end
    report_test($sformatf("transfer %0d %s %s len %0d", t, cur_mode.name(),
                          cur_dir.name(), n), errs_before);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int         errs_before;
    logic [31:0] data;
    logic [1:0]  resp;
    rstn    = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr    = 16'd38061;
    $readmemh("verif/spim_golden.txt", golden);
    n_tests = golden[0];
    if (n_tests < 1 || n_tests > MAX_TESTS) begin
      n_errors++;
      $display("Golden file gives %0d transfers, expected 1 to %0d", n_tests, MAX_TESTS);
      n_tests = 0;
    end
    max_div = 0;
    for (int t = 0; t < n_tests; t++) begin
      if (int'(golden[1 + t * FIELDS][7:0]) > max_div) max_div = golden[1 + t * FIELDS][7:0];
    end
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;

    errs_before = n_errors;
    axi_write(8'h14, 32'h0, resp);  // Hole in the map
    check_resp("bresp unmapped", resp, RESP_SLVERR);
    axi_read(8'h20, data, resp);
    check_resp("rresp unmapped", resp, RESP_SLVERR);
    report_test("unmapped address", errs_before);

    for (int t = 0; t < n_tests; t++) run_transfer(t);

    check_word("b_handshakes", b_seen, n_writes);
    check_word("r_handshakes", r_seen, n_reads);
    $display("%0d transfers, %0d checks, %0d errors, %0d assertion failures",
             n_tests, n_checks, n_errors, u_dut.u_assert.fails);
    if (n_errors == 0 && u_dut.u_assert.fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog, scaled by transfer count and slowest divider
  initial begin
    longint limit;
    wait (loaded);
    limit = longint'(n_tests) * 40 * (max_div + 1) * 40 + 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d clk cycles, a handshake or transfer hung", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verif/spim_assertions.sv
`timescale 1ns/1ps

module spim_assertions (
  input logic       clk,
  input logic       rstn,
  input logic       sclk_i,
  input logic       csn_i,
  input logic       bvalid_i,
  input logic       bready_i,
  input logic [3:0] oe_i
);
  int fails = 0;  // Failure count, read at the end of the run

  // ------------------------------
  // Serial side
  // ------------------------------
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rstn) csn_i |-> !sclk_i)
    else begin
      $error("sclk high while chip select is released");
      fails++;
    end

  a_oe_idle: assert property (@(posedge clk) disable iff (!rstn) csn_i |-> oe_i == 4'b0000)
    else begin
      $error("Output enables set while idle");
      fails++;
    end

  // B must hold until taken
  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
                             bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("BVALID dropped before BREADY");
      fails++;
    end

endmodule

bind spim_top spim_assertions u_assert (
  .clk      (clk),
  .rstn     (rstn),
  .sclk_i   (sclk_o),
  .csn_i    (csn_o),
  .bvalid_i (s_bvalid_o),
  .bready_i (s_bready_i),
  .oe_i     (sdo_oe_o)
);

// File: logic/spim_top.sv
`timescale 1ns/1ps

module spim_top (
  input  logic        clk,
  input  logic        rstn,
  // AXI4-Lite slave
  input  logic [7:0]  s_awaddr_i,
  input  logic        s_awvalid_i,
  output logic        s_awready_o,
  input  logic [31:0] s_wdata_i,
  input  logic        s_wvalid_i,
  output logic        s_wready_o,
  output logic [1:0]  s_bresp_o,
  output logic        s_bvalid_o,
  input  logic        s_bready_i,
  input  logic [7:0]  s_araddr_i,
  input  logic        s_arvalid_i,
  output logic        s_arready_o,
  output logic [31:0] s_rdata_o,
  output logic [1:0]  s_rresp_o,
  output logic        s_rvalid_o,
  input  logic        s_rready_i,
  // Serial side, pads outside
  output logic        sclk_o,
  output logic        csn_o,
  output logic [3:0]  sdo_o,
  output logic [3:0]  sdo_oe_o,  // One enable per data line
  input  logic [3:0]  sdi_i
);
  import spim_pkg::*;

  spim_cmd_t        cmd;
  logic             cmd_start;
  logic [DIV_W-1:0] div;
  logic             busy;
  logic             xfer_done;
  logic             clk_en;
  logic             tx_edge;
  logic             rx_edge;
  logic [31:0]      rx_word;

  // ------------------------------
  // Register block
  // ------------------------------
  spim_regs u_regs (
    .clk         (clk),
    .rstn        (rstn),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .cmd_o       (cmd),
    .cmd_start_o (cmd_start),
    .div_o       (div),
    .busy_i      (busy),
    .xfer_done_i (xfer_done),
    .rx_word_i   (rx_word)
  );

  // ------------------------------
  // Serial engine
  // ------------------------------
  spim_clkgen u_clkgen (
    .clk       (clk),
    .rstn      (rstn),
    .clk_en_i  (clk_en),
    .div_i     (div),
    .sclk_o    (sclk_o),
    .tx_edge_o (tx_edge),
    .rx_edge_o (rx_edge)
  );

  spim_tx u_tx (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_i       (cmd),
    .cmd_start_i (cmd_start),
    .tx_edge_i   (tx_edge),
    .busy_o      (busy),
    .xfer_done_o (xfer_done),
    .clk_en_o    (clk_en),
    .csn_o       (csn_o),
    .sdo_o       (sdo_o),
    .sdo_oe_o    (sdo_oe_o)
  );

  spim_rx u_rx (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_i       (cmd),
    .cmd_start_i (cmd_start),
    .busy_i      (busy),
    .rx_edge_i   (rx_edge),
    .sdi_i       (sdi_i),
    .rx_word_o   (rx_word)
  );

endmodule

// File: logic/spim_rx.sv
`timescale 1ns/1ps

module spim_rx (
  input  logic                clk,
  input  logic                rstn,
  input  spim_pkg::spim_cmd_t cmd_i,
  input  logic                cmd_start_i,
  input  logic                busy_i,
  input  logic                rx_edge_i,  // Rising sclk strobe
  input  logic [3:0]          sdi_i,
  output logic [31:0]         rx_word_o   // Right-aligned result
);
  import spim_pkg::*;

  spim_mode_e  mode_q;      // Lanes sampled per edge
  logic [5:0]  len_q;       // Effective length, 1 to 32
  logic [31:0] shift_q;
  logic [31:0] shift_next;
  logic [31:0] len_mask;

  // ------------------------------
  // Lane selection per mode
  // ------------------------------
  always_comb begin
    case (mode_q)
      MODE_QUAD: shift_next = {shift_q[27:0], sdi_i[3:0]};  // Line 3 is the MSB
      MODE_DUAL: shift_next = {shift_q[29:0], sdi_i[1:0]};
      default:   shift_next = {shift_q[30:0], sdi_i[1]};    // MISO on line 1
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mode_q  <= MODE_SINGLE;
      len_q   <= 6'd32;
      shift_q <= '0;
    end else if (cmd_start_i) begin
      // Fresh word, old result dropped
      mode_q  <= cmd_i.mode;
      len_q   <= spim_len(cmd_i.len);
      shift_q <= '0;
    end else if (busy_i && rx_edge_i) begin
      shift_q <= shift_next;
    end
  end

  // Extra bits of a rounded-up last edge fall off the top
  assign len_mask  = (len_q == 6'd32) ? '1 : ((32'd1 << len_q) - 32'd1);
  assign rx_word_o = shift_q & len_mask;

endmodule

// File: logic/spim_tx.sv
`timescale 1ns/1ps

module spim_tx (
  input  logic                clk,
  input  logic                rstn,
  input  spim_pkg::spim_cmd_t cmd_i,
  input  logic                cmd_start_i,
  input  logic                tx_edge_i,    // Falling sclk strobe
  output logic                busy_o,
  output logic                xfer_done_o,  // Pulses with CS release
  output logic                clk_en_o,     // Lets sclk run
  output logic                csn_o,
  output logic [3:0]          sdo_o,
  output logic [3:0]          sdo_oe_o
);
  import spim_pkg::*;

  spim_tx_state_e state_q;
  spim_mode_e     mode_q;       // Lane count for this word
  spim_dir_e      dir_q;
  logic [5:0]     edge_cnt_q;   // Falling edges seen in TX_SHIFT
  logic [5:0]     edge_trgt_q;  // Edges for the whole word, scaled by mode
  logic [31:0]    shift_q;      // MSB is the next bit out
  logic [31:0]    shift_next;
  logic           last_edge;

  // ------------------------------
  // Line levels and enables
  // ------------------------------
  function automatic logic [3:0] line_levels(spim_mode_e mode, spim_dir_e dir,
                                             logic [31:0] word);
    logic [3:0] lv;
    lv = 4'b1100;  // Idle, WP and HOLD high
    if (dir == DIR_WRITE) begin
      case (mode)
        MODE_QUAD: lv = word[31:28];            // Line 3 carries the MSB
        MODE_DUAL: lv = {2'b11, word[31:30]};
        default:   lv = {3'b110, word[31]};     // Line 1 unused on output
      endcase
    end
    return lv;
  endfunction

  function automatic logic [3:0] line_oe(spim_mode_e mode, spim_dir_e dir);
    logic [3:0] oe;
    if (mode == MODE_SINGLE) begin
      oe = 4'b1101;  // Line 1 is MISO
    end else if (dir == DIR_READ) begin
      oe = 4'b0000;  // Lanes turned around for input
    end else begin
      oe = 4'b1111;
    end
    return oe;
  endfunction

  // Word after one shift step
  always_comb begin
    case (mode_q)
      MODE_QUAD: shift_next = {shift_q[27:0], 4'b0000};
      MODE_DUAL: shift_next = {shift_q[29:0], 2'b00};
      default:   shift_next = {shift_q[30:0], 1'b0};
    endcase
  end

  assign last_edge = (edge_cnt_q == edge_trgt_q - 6'd1);
  assign busy_o    = (state_q != TX_IDLE);
  assign clk_en_o  = (state_q == TX_SHIFT);

  always_ff @(posedge clk) begin
    if (state_q == TX_IDLE && cmd_start_i) begin
      shift_q <= cmd_i.txdata;
    end else if (state_q == TX_SHIFT && tx_edge_i && !last_edge) begin
      shift_q <= shift_next;
    end
  end

  // ------------------------------
  // Transfer FSM
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= TX_IDLE;
      mode_q      <= MODE_SINGLE;
      dir_q       <= DIR_WRITE;
      edge_cnt_q  <= '0;
      edge_trgt_q <= '0;
      csn_o       <= 1'b1;
      sdo_o       <= 4'b1100;
      sdo_oe_o    <= 4'b0000;
      xfer_done_o <= 1'b0;
    end else begin
      xfer_done_o <= 1'b0;
      case (state_q)
        TX_IDLE: if (cmd_start_i) begin
          mode_q      <= cmd_i.mode;
          dir_q       <= cmd_i.dir;
          edge_trgt_q <= spim_edges(cmd_i.mode, cmd_i.len);
          edge_cnt_q  <= '0;
          csn_o       <= 1'b0;
          sdo_o       <= line_levels(cmd_i.mode, cmd_i.dir, cmd_i.txdata);  // First bits
          sdo_oe_o    <= line_oe(cmd_i.mode, cmd_i.dir);
          state_q     <= TX_SETUP;
        end
        TX_SETUP: if (tx_edge_i) state_q <= TX_SHIFT;  // Phase aligned, sclk may start
        TX_SHIFT: if (tx_edge_i) begin
          if (last_edge) begin
            state_q <= TX_END;  // Last rising edge already past
          end else begin
            edge_cnt_q <= edge_cnt_q + 6'd1;
            sdo_o      <= line_levels(mode_q, dir_q, shift_next);
          end
        end
        TX_END: if (tx_edge_i) begin
          csn_o       <= 1'b1;
          sdo_o       <= 4'b1100;
          sdo_oe_o    <= 4'b0000;
          xfer_done_o <= 1'b1;
          state_q     <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

// File: logic/spim_clkgen.sv
`timescale 1ns/1ps

module spim_clkgen (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       clk_en_i,   // High through TX_SHIFT
  input  logic [spim_pkg::DIV_W-1:0] div_i,      // Half period minus one
  output logic                       sclk_o,
  output logic                       tx_edge_o,  // sclk falls on this clk edge
  output logic                       rx_edge_o   // sclk rises on this clk edge
);
  import spim_pkg::*;

  logic [DIV_W-1:0] cnt_q;    // Down-counter to the next half-period tick
  logic             phase_q;  // Half-period phase, runs between transfers too
  logic             en_q;     // Enable one cycle back
  logic             tick;

  assign tick      = (cnt_q == '0);
  assign tx_edge_o = tick & phase_q;              // Keeps pulsing while idle
  assign rx_edge_o = tick & ~phase_q & clk_en_i;  // Only with sclk running

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_q   <= '0;
      phase_q <= 1'b0;
      en_q    <= 1'b0;
      sclk_o  <= 1'b0;
    end else begin
      en_q <= clk_en_i;
      if (en_q && !clk_en_i) begin  // Enable dropped, restart the phase
        cnt_q   <= '0;
        phase_q <= 1'b0;
      end else if (tick) begin
        cnt_q   <= div_i;
        phase_q <= ~phase_q;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
      // sclk follows the phase only while enabled
      if (!clk_en_i) begin
        sclk_o <= 1'b0;
      end else if (tick) begin
        sclk_o <= ~phase_q;
      end
    end
  end

endmodule

// File: logic/spim_regs.sv
`timescale 1ns/1ps

module spim_regs (
  input  logic                       clk,
  input  logic                       rstn,
  // AXI4-Lite write side
  input  logic [7:0]                 s_awaddr_i,
  input  logic                       s_awvalid_i,
  output logic                       s_awready_o,
  input  logic [31:0]                s_wdata_i,
  input  logic                       s_wvalid_i,
  output logic                       s_wready_o,
  output logic [1:0]                 s_bresp_o,
  output logic                       s_bvalid_o,
  input  logic                       s_bready_i,
  // AXI4-Lite read side
  input  logic [7:0]                 s_araddr_i,
  input  logic                       s_arvalid_i,
  output logic                       s_arready_o,
  output logic [31:0]                s_rdata_o,
  output logic [1:0]                 s_rresp_o,
  output logic                       s_rvalid_o,
  input  logic                       s_rready_i,
  // Core side
  output spim_pkg::spim_cmd_t        cmd_o,
  output logic                       cmd_start_o,  // One cycle per accepted CMD
  output logic [spim_pkg::DIV_W-1:0] div_o,
  input  logic                       busy_i,
  input  logic                       xfer_done_i,
  input  logic [31:0]                rx_word_i
);
  import spim_pkg::*;

  logic         aw_held_q;  // Address taken, data still missing
  logic [7:0]   awaddr_q;
  logic         w_held_q;   // Data taken, address still missing
  logic [31:0]  wdata_q;
  logic         aw_ok;
  logic         w_ok;
  logic         wr_go;      // Both halves present this cycle
  logic [7:0]   wr_addr;
  logic [31:0]  wr_data;
  logic [1:0]   wr_resp;
  spim_mode_e   wr_mode;
  logic [31:0]  txdata_q;
  logic         done_q;
  spim_status_t status;
  logic [31:0]  rd_data;
  logic [1:0]   rd_resp;

  // Start pulse counts as busy, tx sees it one cycle later
  // Done pulse too, the sticky flag only lands a cycle after it
  assign status.busy = busy_i | cmd_start_o | xfer_done_i;
  assign status.done = done_q;

  assign aw_ok   = aw_held_q | (s_awvalid_i & s_awready_o);
  assign w_ok    = w_held_q | (s_wvalid_i & s_wready_o);
  assign wr_go   = aw_ok & w_ok;
  assign wr_addr = aw_held_q ? awaddr_q : s_awaddr_i;
  assign wr_data = w_held_q ? wdata_q : s_wdata_i;
  // CMD layout: [1:0] mode, [4] dir, [13:8] len; mode 3 falls back to single
  assign wr_mode = (wr_data[1:0] == 2'b11) ? MODE_SINGLE : spim_mode_e'(wr_data[1:0]);

  // ------------------------------
  // Write channel
  // ------------------------------
  always_comb begin
    case (wr_addr)
      REG_CTRL, REG_TXDATA, REG_STATUS, REG_RXDATA: wr_resp = RESP_OKAY;
      REG_CMD: wr_resp = status.busy ? RESP_SLVERR : RESP_OKAY;  // No restart mid-word
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (s_awvalid_i && s_awready_o) awaddr_q <= s_awaddr_i;
    if (s_wvalid_i && s_wready_o) wdata_q <= s_wdata_i;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s_awready_o <= 1'b0;
      s_wready_o  <= 1'b0;
      aw_held_q   <= 1'b0;
      w_held_q    <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_bresp_o   <= RESP_OKAY;
    end else begin
      s_awready_o <= s_awvalid_i & ~s_awready_o & ~aw_ok & ~s_bvalid_o;
      s_wready_o  <= s_wvalid_i & ~s_wready_o & ~w_ok & ~s_bvalid_o;
      aw_held_q   <= aw_ok & ~wr_go;
      w_held_q    <= w_ok & ~wr_go;
      if (wr_go) begin
        s_bvalid_o <= 1'b1;
        s_bresp_o  <= wr_resp;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
    end
  end

  // Register file and command issue
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      div_o       <= '0;
      txdata_q    <= '0;
      cmd_o       <= '0;
      cmd_start_o <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      cmd_start_o <= 1'b0;
      if (xfer_done_i) done_q <= 1'b1;
      if (wr_go && wr_resp == RESP_OKAY) begin
        case (wr_addr)
          REG_CTRL:   div_o <= wr_data[DIV_W-1:0];
          REG_TXDATA: txdata_q <= wr_data;
          REG_CMD: begin
            cmd_o.mode   <= wr_mode;
            cmd_o.dir    <= spim_dir_e'(wr_data[4]);
            cmd_o.len    <= wr_data[13:8];
            cmd_o.txdata <= txdata_q;
            cmd_start_o  <= 1'b1;
            done_q       <= 1'b0;  // New word, done clears
          end
          default: ;               // Read-only registers ignore writes
        endcase
      end
    end
  end

  // ------------------------------
  // Read channel
  // ------------------------------
  always_comb begin
    rd_resp = RESP_OKAY;
    case (s_araddr_i)
      REG_CTRL:   rd_data = {{(32-DIV_W){1'b0}}, div_o};
      REG_TXDATA: rd_data = txdata_q;
      REG_CMD:    rd_data = {18'd0, cmd_o.len, 3'd0, cmd_o.dir, 2'd0, cmd_o.mode};
      REG_STATUS: rd_data = {30'd0, status};
      REG_RXDATA: rd_data = rx_word_i;
      default: begin
        rd_data = '0;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
      s_rdata_o   <= '0;
      s_rresp_o   <= RESP_OKAY;
    end else begin
      s_arready_o <= s_arvalid_i & ~s_arready_o & ~s_rvalid_o;
      if (s_arvalid_i && s_arready_o) begin
        s_rvalid_o <= 1'b1;
        s_rdata_o  <= rd_data;
        s_rresp_o  <= rd_resp;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

// File: logic/spim_pkg.sv
package spim_pkg;

  // ------------------------------
  // Bus modes, direction, states
  // ------------------------------
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,  // Line 0 out, line 1 in
    MODE_DUAL   = 2'd1,  // Lines 1..0
    MODE_QUAD   = 2'd2   // Lines 3..0
  } spim_mode_e;

  typedef enum logic {
    DIR_WRITE = 1'b0,  // Drive the data lanes
    DIR_READ  = 1'b1   // Release the input lanes
  } spim_dir_e;

  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_SETUP = 2'd1,  // CS low, first bits on the lines
    TX_SHIFT = 2'd2,  // sclk running
    TX_END   = 2'd3   // Wait one edge before CS release
  } spim_tx_state_e;

  typedef struct packed {
    spim_mode_e  mode;
    spim_dir_e   dir;
    logic [5:0]  len;     // Bit count, 0 reads as 32
    logic [31:0] txdata;
  } spim_cmd_t;

  typedef struct packed {
    logic busy;
    logic done;  // Sticky until the next command
  } spim_status_t;

  // Register map, byte offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_TXDATA = 8'h04;
  localparam logic [7:0] REG_CMD    = 8'h08;
  localparam logic [7:0] REG_STATUS = 8'h0C;
  localparam logic [7:0] REG_RXDATA = 8'h10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam int DIV_W = 8;  // Half period is div + 1 clk cycles

  // Effective bit count, 1 to 32
  function automatic logic [5:0] spim_len(logic [5:0] len);
    return (len == 6'd0 || len > 6'd32) ? 6'd32 : len;
  endfunction

  // Rising sclk edges for one word, rounded up per lane count
  function automatic logic [5:0] spim_edges(spim_mode_e mode, logic [5:0] len);
    logic [5:0] n;
    n = spim_len(len);
    case (mode)
      MODE_QUAD: return (n + 6'd3) >> 2;
      MODE_DUAL: return (n + 6'd1) >> 1;
      default:   return n;
    endcase
  endfunction

endpackage
